//--- verilog.f
logic/stbuf_cfg_pkg.sv
logic/stbuf_types_pkg.sv
logic/stbuf_store_split.sv
logic/stbuf_commit_pipe.sv
logic/stbuf_entries.sv
logic/stbuf_load_fwd.sv
logic/stbuf_top.sv
verif/stbuf_assertions.sv
verif/stbuf_checker.sv
verif/stbuf_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the store buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module stbuf_tb -f verilog.f -o stbuf_sim
./obj_dir/stbuf_sim 2>&1 | tee sim.log

if grep -q '^RESULT: PASS$' sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

//--- verif/stbuf_tb.sv
module stbuf_tb;
   timeunit 1ns;
   timeprecision 1ns;
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;

   localparam int         T4_ROUNDS   = 12;
   localparam int         NUM_OPS     = 1 + 2 + 3 + 2 + 2 * T4_ROUNDS + 3;
   localparam int         CYCLE_LIMIT = 40 * NUM_OPS + 200;
   localparam store_req_t NO_STORE    = '0;
   localparam load_req_t  NO_LOAD     = '0;

   logic          clk;
   logic          rst;
   store_req_t    store_req;
   logic          commit_dc5;
   load_req_t     load_req;
   logic          drain_ack;
   logic          drain_vld;
   logic          drain_flushed;
   stbuf_entry_t  drain_entry;
   logic          full;
   logic          empty;
   fwd_result_t   fwd_lo;
   fwd_result_t   fwd_hi;

   logic [31:0]   lfsr;
   logic [1:0]    cmt_q;    // commit level for the stores one and two cycles back
   logic          ack_on;
   int            chk_errors;
   int            chk_checks;
   int            tb_errors;
   int            err_mark;
   int            tests_run;
   int            tests_failed;

   stbuf_top DUT (
      .clk           (clk),
      .rst           (rst),
      .store_req     (store_req),
      .commit_dc5    (commit_dc5),
      .load_req      (load_req),
      .drain_ack     (drain_ack),
      .drain_vld     (drain_vld),
      .drain_flushed (drain_flushed),
      .drain_entry   (drain_entry),
      .full          (full),
      .empty         (empty),
      .fwd_lo        (fwd_lo),
      .fwd_hi        (fwd_hi)
   );

   stbuf_checker chk (
      .clk           (clk),
      .rst           (rst),
      .store_req     (store_req),
      .commit_dc5    (commit_dc5),
      .load_req      (load_req),
      .drain_ack     (drain_ack),
      .drain_vld     (drain_vld),
      .drain_flushed (drain_flushed),
      .drain_entry   (drain_entry),
      .full          (full),
      .empty         (empty),
      .fwd_lo        (fwd_lo),
      .fwd_hi        (fwd_hi),
      .errors        (chk_errors),
      .checks        (chk_checks)
   );

   bind stbuf_entries stbuf_assertions u_sva (
      .clk       (clk),
      .rst       (rst),
      .data_vld  (data_vld),
      .drain_rdy (drain_rdy),
      .flush_vld (flush_vld),
      .drain_ack (drain_ack),
      .drain_vld (drain_vld)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      for (int n = 0; n < CYCLE_LIMIT; n++) begin
         @(posedge clk);
      end
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
   end

   // galois lfsr with one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic access_size_t rand_size();
      logic [1:0] r;
      r = 2'(rand_bits(2));
      return (r == 2'd0) ? size_byte : (r == 2'd1) ? size_half : size_word;
   endfunction

   // ---------------------------------------------------------------------
   // drivers called right after a falling edge
   // ---------------------------------------------------------------------
   task automatic drive(input store_req_t s, input logic cmt, input load_req_t l);
      logic [1:0] gap;
      gap        = 2'(rand_bits(2));
      drain_ack  = ack_on & drain_vld & (gap == 2'd0);   // ack roughly one cycle in four
      store_req  = s;
      load_req   = l;
      commit_dc5 = cmt_q[1];
      cmt_q      = {cmt_q[0], cmt};
   endtask

   task automatic send_store(input logic [15:0] a, input access_size_t sz,
                             input logic [31:0] d, input logic cmt);
      store_req_t s;
      s = '{vld: 1'b1, addr: a, size: sz, data: d};
      @(negedge clk);
      while (full) begin
         drive(NO_STORE, 1'b0, NO_LOAD);
         @(negedge clk);
      end
      drive(s, cmt, NO_LOAD);
   endtask

   task automatic send_load(input logic [15:0] a, input access_size_t sz);
      @(negedge clk);
      drive(NO_STORE, 1'b0, '{vld: 1'b1, addr: a, size: sz});
   endtask

   task automatic drain_all();
      ack_on = 1'b1;
      do begin
         @(negedge clk);
         drive(NO_STORE, 1'b0, NO_LOAD);
      end while (!empty);
   endtask

   task automatic check_level(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("mismatch at %0t ns: %s expected %b actual %b", $time, name, exp, act);
         tb_errors++;
      end
   endtask

   task automatic end_test(input string name);
      int errs;
      errs      = chk_errors + tb_errors - err_mark;
      err_mark  = chk_errors + tb_errors;
      tests_run++;
      if (errs != 0) begin
         tests_failed++;
      end
      $display("test %0d %s: %s", tests_run, name, (errs == 0) ? "ok" : "failed");
   endtask

   initial begin
      rst          = 1'b1;
      store_req    = NO_STORE;
      load_req     = NO_LOAD;
      commit_dc5   = 1'b0;
      drain_ack    = 1'b0;
      lfsr         = 32'h6de0;
      cmt_q        = 2'b00;
      ack_on       = 1'b1;
      tb_errors    = 0;
      err_mark     = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (16) @(negedge clk);
      rst = 1'b0;

      send_store(16'h0100, size_word, 32'ha1b2_c3d4, 1'b1);
      drain_all();
      end_test("aligned word drain");

      send_store(16'h0203, size_half, 32'h0000_beef, 1'b1);
      send_store(16'h0306, size_word, 32'h1122_3344, 1'b1);
      drain_all();
      end_test("crossing stores split");

      send_store(16'h0400, size_word, 32'h0badf00d, 1'b1);
      send_store(16'h0413, size_half, 32'h0000_5a5a, 1'b0);   // crossing store killed in dc5
      send_store(16'h0421, size_half, 32'h0000_c0de, 1'b1);
      drain_all();
      end_test("flush and order");

      send_store(16'h0606, size_word, 32'hcafe_f00d, 1'b1);
      send_load(16'h0605, size_word);
      for (int i = 0; i < T4_ROUNDS; i++) begin
         send_store(16'h0500 | 16'(rand_bits(4)), rand_size(), rand_bits(32),
                    rand_bits(2) != 0);
         send_load(16'h0500 | 16'(rand_bits(4)), rand_size());
      end
      drain_all();
      end_test("load forwarding");

      ack_on = 1'b0;
      send_store(16'h0700, size_word, 32'h7070_0000, 1'b1);
      send_store(16'h0704, size_word, 32'h7070_0004, 1'b1);
      send_store(16'h0708, size_word, 32'h7070_0008, 1'b1);
      repeat (6) begin
         @(negedge clk);
         drive(NO_STORE, 1'b0, NO_LOAD);
      end
      check_level("full", 1'b1, full);             // three entries held
      check_level("drain_vld", 1'b1, drain_vld);   // head still offered
      drain_all();
      check_level("full", 1'b0, full);
      end_test("back-pressure");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, chk_checks, chk_errors + tb_errors);
      if (tests_failed == 0 && chk_errors + tb_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- verif/stbuf_checker.sv
module stbuf_checker (
   input  logic                          clk,
   input  logic                          rst,
   input  stbuf_types_pkg::store_req_t   store_req,
   input  logic                          commit_dc5,
   input  stbuf_types_pkg::load_req_t    load_req,
   input  logic                          drain_ack,
   input  logic                          drain_vld,
   input  logic                          drain_flushed,
   input  stbuf_types_pkg::stbuf_entry_t drain_entry,
   input  logic                          full,
   input  logic                          empty,
   input  stbuf_types_pkg::fwd_result_t  fwd_lo,
   input  stbuf_types_pkg::fwd_result_t  fwd_hi,
   output int                            errors,
   output int                            checks
);
   timeunit 1ns;
   timeprecision 1ns;
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;

   typedef enum logic [1:0] {st_pend, st_commit, st_flush} ent_state_t;

   typedef struct packed {
      stbuf_entry_t ent;
      ent_state_t   state;
      logic [31:0]  wcyc;   // cycle of the store request
   } model_ent_t;

   model_ent_t  q[$];   // oldest at the front
   fwd_result_t exp_lo;
   fwd_result_t exp_hi;
   logic [31:0] cyc;

   function automatic int size_bytes(input access_size_t sz);
      case (sz)
         size_byte: return 1;
         size_half: return 2;
         default:   return 4;
      endcase
   endfunction

   function automatic logic crosses(input logic [1:0] off, input access_size_t sz);
      return (int'(off) + size_bytes(sz)) > BYTE_W;
   endfunction

   // ---------------------------------------------------------------------
   // reference forward where the youngest entry claims each byte first
   // ---------------------------------------------------------------------
   function automatic fwd_result_t ref_forward(input logic [ADDR_W-1:WORD_ADDR_LSB] word);
      fwd_result_t r;
      r = '0;
      for (int i = q.size() - 1; i >= 0; i--) begin
         if (q[i].state != st_flush && q[i].ent.addr[ADDR_W-1:WORD_ADDR_LSB] == word) begin
            for (int b = 0; b < BYTE_W; b++) begin
               if (q[i].ent.byteen[b] && !r.byteen[b]) begin
                  r.byteen[b]       = 1'b1;
                  r.data[8*b +: 8] = q[i].ent.data[8*b +: 8];
               end
            end
         end
      end
      return r;
   endfunction

   // each data byte k lands on lane offset+k of a two word window
   task automatic push_store(input store_req_t s);
      logic [2*DATA_W-1:0] d;
      logic [2*BYTE_W-1:0] be;
      int                  off;
      model_ent_t          m;
      d   = '0;
      be  = '0;
      off = int'(s.addr[1:0]);
      for (int k = 0; k < BYTE_W; k++) begin
         d[8*(off+k) +: 8] = s.data[8*k +: 8];
         be[off+k]         = (k < size_bytes(s.size));
      end
      m.state      = st_pend;
      m.wcyc       = cyc;
      m.ent.addr   = s.addr;
      m.ent.byteen = be[BYTE_W-1:0];
      m.ent.data   = d[DATA_W-1:0];
      q.push_back(m);
      if (crosses(s.addr[1:0], s.size)) begin
         m.ent.addr   = (s.addr & 16'hfffc) + 16'd4;   // next word
         m.ent.byteen = be[2*BYTE_W-1:BYTE_W];
         m.ent.data   = d[2*DATA_W-1:DATA_W];
         q.push_back(m);
      end
   endtask

   task automatic compare_val(input string name, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      if (exp !== act) begin
         $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
         errors++;
      end
   endtask

   always @(posedge clk) begin
      logic                          exp_vld;
      logic                          exp_fl;
      logic [ADDR_W-1:WORD_ADDR_LSB] ld_word;
      model_ent_t                    m;
      if (rst) begin
         q.delete();
         cyc    = '0;
         exp_lo = '0;
         exp_hi = '0;
         errors = 0;
         checks = 0;
      end else begin
         exp_vld = (q.size() > 0) && (q[0].state == st_commit);
         exp_fl  = (q.size() > 0) && (q[0].state == st_flush);
         compare_val("empty", 64'(q.size() == 0), 64'(empty));
         compare_val("full", 64'((STBUF_DEPTH - q.size()) < 2), 64'(full));
         compare_val("drain_vld", 64'(exp_vld), 64'(drain_vld));
         compare_val("drain_flushed", 64'(exp_fl), 64'(drain_flushed));
         if (exp_vld) begin
            compare_val("drain_entry", 64'(q[0].ent), 64'(drain_entry));
         end
         if (drain_ack && !exp_vld) begin
            $display("error at %0t ns: drain_ack with no committed entry at the head", $time);
            errors++;
         end
         compare_val("fwd_lo", 64'(exp_lo), 64'(fwd_lo));
         compare_val("fwd_hi", 64'(exp_hi), 64'(fwd_hi));

         // load result seen during the next cycle
         ld_word = load_req.addr[ADDR_W-1:WORD_ADDR_LSB];
         exp_lo  = load_req.vld ? ref_forward(ld_word) : '0;
         exp_hi  = (load_req.vld && crosses(load_req.addr[1:0], load_req.size)) ?
                   ref_forward(ld_word + 1'b1) : '0;

         if ((exp_vld && drain_ack) || exp_fl) begin
            q.pop_front();
         end
         foreach (q[i]) begin
            if (q[i].state == st_pend && q[i].wcyc == cyc - 2) begin   // store now in dc5
               m       = q[i];
               m.state = commit_dc5 ? st_commit : st_flush;
               q[i]    = m;
            end
         end
         if (store_req.vld) begin
            push_store(store_req);
         end
         cyc = cyc + 1;
      end
   end

endmodule

//--- verif/stbuf_assertions.sv
module stbuf_assertions (
   input logic                                  clk,
   input logic                                  rst,
   input logic [stbuf_cfg_pkg::STBUF_DEPTH-1:0] data_vld,
   input logic [stbuf_cfg_pkg::STBUF_DEPTH-1:0] drain_rdy,
   input logic [stbuf_cfg_pkg::STBUF_DEPTH-1:0] flush_vld,
   input logic                                  drain_ack,
   input logic                                  drain_vld
);
   timeunit 1ns;
   timeprecision 1ns;

   // state bits only live on an occupied slot
   drain_bit_on_valid: assert property (@(posedge clk) disable iff (rst)
      (drain_rdy & ~data_vld) == '0)
      else $error("drain bit set on a slot that holds no entry");

   flush_bit_on_valid: assert property (@(posedge clk) disable iff (rst)
      (flush_vld & ~data_vld) == '0)
      else $error("flush bit set on a slot that holds no entry");

   drain_flush_exclusive: assert property (@(posedge clk) disable iff (rst)
      (drain_rdy & flush_vld) == '0)
      else $error("slot marked for drain and flush at once");

   ack_needs_offer: assert property (@(posedge clk) disable iff (rst)
      drain_ack |-> drain_vld)
      else $error("drain_ack arrived while no entry was offered");

endmodule

//--- logic/stbuf_top.sv
module stbuf_top (
   input  logic                          clk,
   input  logic                          rst,
   input  stbuf_types_pkg::store_req_t   store_req,
   input  logic                          commit_dc5,
   input  stbuf_types_pkg::load_req_t    load_req,
   input  logic                          drain_ack,
   output logic                          drain_vld,
   output logic                          drain_flushed,
   output stbuf_types_pkg::stbuf_entry_t drain_entry,
   output logic                          full,
   output logic                          empty,
   output stbuf_types_pkg::fwd_result_t  fwd_lo,
   output stbuf_types_pkg::fwd_result_t  fwd_hi
);
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;

   logic                            wr_req;
   logic                            is_dual;
   stbuf_entry_t                    lo_entry;
   stbuf_entry_t                    hi_entry;
   logic [STBUF_PTR_W-1:0]          wr_ptr;
   stbuf_entry_t [STBUF_DEPTH-1:0]  entry_arr;
   logic [STBUF_DEPTH-1:0]          data_vld;
   logic [STBUF_DEPTH-1:0]          flush_vld;
   logic [STBUF_DEPTH-1:0]          drain_en;
   logic [STBUF_DEPTH-1:0]          flush_en;

   // dc3 write path
   stbuf_store_split u_split (
      .store_req (store_req),
      .wr_req    (wr_req),
      .is_dual   (is_dual),
      .lo_entry  (lo_entry),
      .hi_entry  (hi_entry)
   );

   stbuf_commit_pipe u_commit (
      .clk        (clk),
      .rst        (rst),
      .wr_req     (wr_req),
      .is_dual    (is_dual),
      .wr_ptr     (wr_ptr),
      .commit_dc5 (commit_dc5),
      .drain_en   (drain_en),
      .flush_en   (flush_en)
   );

   stbuf_entries u_entries (
      .clk           (clk),
      .rst           (rst),
      .wr_req        (wr_req),
      .is_dual       (is_dual),
      .lo_entry      (lo_entry),
      .hi_entry      (hi_entry),
      .drain_en      (drain_en),
      .flush_en      (flush_en),
      .drain_ack     (drain_ack),
      .wr_ptr        (wr_ptr),
      .entry_arr     (entry_arr),
      .data_vld      (data_vld),
      .flush_vld     (flush_vld),
      .drain_vld     (drain_vld),
      .drain_flushed (drain_flushed),
      .drain_entry   (drain_entry),
      .full          (full),
      .empty         (empty)
   );

   // dc2 load lookup
   stbuf_load_fwd u_fwd (
      .clk       (clk),
      .rst       (rst),
      .load_req  (load_req),
      .wr_ptr    (wr_ptr),
      .entry_arr (entry_arr),
      .data_vld  (data_vld),
      .flush_vld (flush_vld),
      .fwd_lo    (fwd_lo),
      .fwd_hi    (fwd_hi)
   );

endmodule

//--- logic/stbuf_load_fwd.sv
module stbuf_load_fwd (
   input  logic                                  clk,
   input  logic                                  rst,
   input  stbuf_types_pkg::load_req_t            load_req,
   input  logic [stbuf_cfg_pkg::STBUF_PTR_W-1:0] wr_ptr,
   input  stbuf_types_pkg::stbuf_entry_t [stbuf_cfg_pkg::STBUF_DEPTH-1:0] entry_arr,
   input  logic [stbuf_cfg_pkg::STBUF_DEPTH-1:0] data_vld,
   input  logic [stbuf_cfg_pkg::STBUF_DEPTH-1:0] flush_vld,
   output stbuf_types_pkg::fwd_result_t          fwd_lo,
   output stbuf_types_pkg::fwd_result_t          fwd_hi
);
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;

   logic [WORD_ADDR_LSB-1:0]        span;       // bytes past the first one
   logic [WORD_ADDR_LSB:0]          end_off;
   logic                            ld_dual;
   logic [ADDR_W-1:WORD_ADDR_LSB]   cmp_lo;
   logic [ADDR_W-1:WORD_ADDR_LSB]   cmp_hi;
   logic [STBUF_DEPTH-1:0]          match_lo;
   logic [STBUF_DEPTH-1:0]          match_hi;
   fwd_result_t                     nxt_lo;
   fwd_result_t                     nxt_hi;

   always_comb begin
      case (load_req.size)
         size_byte: span = 2'd0;
         size_half: span = 2'd1;
         default:   span = 2'd3;
      endcase
   end

   assign end_off = {1'b0, load_req.addr[WORD_ADDR_LSB-1:0]} + {1'b0, span};
   assign ld_dual = end_off[WORD_ADDR_LSB];   // last byte in the next word

   assign cmp_lo = load_req.addr[ADDR_W-1:WORD_ADDR_LSB];
   assign cmp_hi = cmp_lo + 1'b1;

   always_comb begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         match_lo[i] = data_vld[i] & ~flush_vld[i] &
                       (entry_arr[i].addr[ADDR_W-1:WORD_ADDR_LSB] == cmp_lo);
         match_hi[i] = data_vld[i] & ~flush_vld[i] & ld_dual &
                       (entry_arr[i].addr[ADDR_W-1:WORD_ADDR_LSB] == cmp_hi);
      end
   end

   // ---------------------------------------------------------------------
   // byte merge from the oldest slot so younger stores overwrite
   // ---------------------------------------------------------------------
   always_comb begin : merge
      logic [STBUF_PTR_W-1:0] slot;
      nxt_lo = '0;
      nxt_hi = '0;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         slot = wr_ptr + STBUF_PTR_W'(i);   // walk starts just past the youngest entry
         for (int b = 0; b < BYTE_W; b++) begin
            if (match_lo[slot] & entry_arr[slot].byteen[b]) begin
               nxt_lo.byteen[b]     = 1'b1;
               nxt_lo.data[8*b +: 8] = entry_arr[slot].data[8*b +: 8];
            end
            if (match_hi[slot] & entry_arr[slot].byteen[b]) begin
               nxt_hi.byteen[b]     = 1'b1;
               nxt_hi.data[8*b +: 8] = entry_arr[slot].data[8*b +: 8];
            end
         end
      end
   end

   // dc3 result register
   always_ff @(posedge clk) begin
      if (rst || !load_req.vld) begin
         fwd_lo <= '0;
         fwd_hi <= '0;
      end else begin
         fwd_lo <= nxt_lo;
         fwd_hi <= nxt_hi;
      end
   end

endmodule

//--- logic/stbuf_entries.sv
module stbuf_entries (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  wr_req,
   input  logic                                  is_dual,
   input  stbuf_types_pkg::stbuf_entry_t         lo_entry,
   input  stbuf_types_pkg::stbuf_entry_t         hi_entry,
   input  logic [stbuf_cfg_pkg::STBUF_DEPTH-1:0] drain_en,
   input  logic [stbuf_cfg_pkg::STBUF_DEPTH-1:0] flush_en,
   input  logic                                  drain_ack,
   output logic [stbuf_cfg_pkg::STBUF_PTR_W-1:0] wr_ptr,
   output stbuf_types_pkg::stbuf_entry_t [stbuf_cfg_pkg::STBUF_DEPTH-1:0] entry_arr,
   output logic [stbuf_cfg_pkg::STBUF_DEPTH-1:0] data_vld,
   output logic [stbuf_cfg_pkg::STBUF_DEPTH-1:0] flush_vld,
   output logic                                  drain_vld,
   output logic                                  drain_flushed,
   output stbuf_types_pkg::stbuf_entry_t         drain_entry,
   output logic                                  full,
   output logic                                  empty
);
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;

   logic [STBUF_PTR_W-1:0] rd_ptr;
   logic [STBUF_PTR_W-1:0] wr_ptr_plus1;
   logic [STBUF_DEPTH-1:0] wr_en_lo;
   logic [STBUF_DEPTH-1:0] wr_en_hi;
   logic [STBUF_DEPTH-1:0] drain_rdy;   // committed and waiting for memory
   logic [STBUF_DEPTH-1:0] pop_vec;
   logic                   pop;
   logic [STBUF_PTR_W:0]   num_vld;

   // ---------------------------------------------------------------------
   // pointers
   // ---------------------------------------------------------------------
   assign wr_ptr_plus1 = wr_ptr + 1'b1;
   assign pop          = drain_ack | drain_flushed;   // flushed head leaves on its own

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_req) begin
            wr_ptr <= wr_ptr_plus1 + STBUF_PTR_W'(is_dual);   // one or two slots
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_comb begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         wr_en_lo[i] = wr_req & (STBUF_PTR_W'(i) == wr_ptr);
         wr_en_hi[i] = wr_req & is_dual & (STBUF_PTR_W'(i) == wr_ptr_plus1);
         pop_vec[i]  = pop & (STBUF_PTR_W'(i) == rd_ptr);
      end
   end

   // ---------------------------------------------------------------------
   // per entry state and storage
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         data_vld  <= '0;
         drain_rdy <= '0;
         flush_vld <= '0;
      end else begin
         data_vld  <= (data_vld | wr_en_lo | wr_en_hi) & ~pop_vec;
         drain_rdy <= (drain_rdy | drain_en) & ~pop_vec;
         flush_vld <= (flush_vld | flush_en) & ~pop_vec;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         if (wr_en_lo[i]) begin
            entry_arr[i] <= lo_entry;
         end else if (wr_en_hi[i]) begin
            entry_arr[i] <= hi_entry;   // upper half of a crossing store
         end
      end
   end

   // head of the queue toward memory
   assign drain_vld     = drain_rdy[rd_ptr];
   assign drain_flushed = flush_vld[rd_ptr];
   assign drain_entry   = entry_arr[rd_ptr];

   // ---------------------------------------------------------------------
   // status
   // ---------------------------------------------------------------------
   always_comb begin
      num_vld = '0;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         num_vld = num_vld + {{STBUF_PTR_W{1'b0}}, data_vld[i]};
      end
   end

   // room must remain for a crossing store
   assign full  = (num_vld > (STBUF_DEPTH - 2));
   assign empty = (num_vld == '0);

endmodule

//--- logic/stbuf_commit_pipe.sv
module stbuf_commit_pipe (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  wr_req,
   input  logic                                  is_dual,
   input  logic [stbuf_cfg_pkg::STBUF_PTR_W-1:0] wr_ptr,
   input  logic                                  commit_dc5,
   output logic [stbuf_cfg_pkg::STBUF_DEPTH-1:0] drain_en,
   output logic [stbuf_cfg_pkg::STBUF_DEPTH-1:0] flush_en
);
   import stbuf_cfg_pkg::*;

   logic                   req_dc4;
   logic                   req_dc5;
   logic                   dual_dc4;
   logic                   dual_dc5;
   logic [STBUF_PTR_W-1:0] ptr_dc4;
   logic [STBUF_PTR_W-1:0] ptr_dc5;
   logic [STBUF_PTR_W-1:0] ptr_plus1_dc5;
   logic [STBUF_DEPTH-1:0] occupied_dc5;

   // ---------------------------------------------------------------------
   // dc3 -> dc4 -> dc5 staging
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         req_dc4  <= 1'b0;
         req_dc5  <= 1'b0;
         dual_dc4 <= 1'b0;
         dual_dc5 <= 1'b0;
      end else begin
         req_dc4  <= wr_req;
         req_dc5  <= req_dc4;
         dual_dc4 <= is_dual;
         dual_dc5 <= dual_dc4;
      end
   end

   always_ff @(posedge clk) begin
      ptr_dc4 <= wr_ptr;   // slot the store was written to
      ptr_dc5 <= ptr_dc4;
   end

   assign ptr_plus1_dc5 = ptr_dc5 + 1'b1;

   // entries owned by the store now in dc5
   always_comb begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         occupied_dc5[i] = req_dc5 & ((STBUF_PTR_W'(i) == ptr_dc5) |
                                      (dual_dc5 & (STBUF_PTR_W'(i) == ptr_plus1_dc5)));
      end
   end

   assign drain_en = occupied_dc5 & {STBUF_DEPTH{commit_dc5}};
   assign flush_en = occupied_dc5 & {STBUF_DEPTH{~commit_dc5}};   // killed in dc5

endmodule

//--- logic/stbuf_store_split.sv
module stbuf_store_split (
   input  stbuf_types_pkg::store_req_t   store_req,
   output logic                          wr_req,
   output logic                          is_dual,
   output stbuf_types_pkg::stbuf_entry_t lo_entry,
   output stbuf_types_pkg::stbuf_entry_t hi_entry
);
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;

   logic [WORD_ADDR_LSB-1:0] offset;
   logic [BYTE_W-1:0]        size_mask;
   logic [2*BYTE_W-1:0]      mask_ext;    // two words of byte enables
   logic [2*DATA_W-1:0]      data_ext;
   logic [ADDR_W-1:0]        next_word_addr;

   assign offset = store_req.addr[WORD_ADDR_LSB-1:0];

   always_comb begin
      case (store_req.size)
         size_byte: size_mask = 4'b0001;
         size_half: size_mask = 4'b0011;
         default:   size_mask = 4'b1111;
      endcase
   end

   assign mask_ext = {{BYTE_W{1'b0}}, size_mask} << offset;
   assign data_ext = {{DATA_W{1'b0}}, store_req.data} << {offset, 3'b000};

   assign wr_req  = store_req.vld;
   assign is_dual = store_req.vld & (|mask_ext[2*BYTE_W-1:BYTE_W]);   // spills into next word

   assign next_word_addr = {store_req.addr[ADDR_W-1:WORD_ADDR_LSB] + 1'b1,
                            {WORD_ADDR_LSB{1'b0}}};

   // lower word keeps the byte address of the store
   assign lo_entry.addr   = store_req.addr;
   assign lo_entry.byteen = mask_ext[BYTE_W-1:0];
   assign lo_entry.data   = data_ext[DATA_W-1:0];

   assign hi_entry.addr   = next_word_addr;
   assign hi_entry.byteen = mask_ext[2*BYTE_W-1:BYTE_W];
   assign hi_entry.data   = data_ext[2*DATA_W-1:DATA_W];

endmodule

//--- logic/stbuf_types_pkg.sv
package stbuf_types_pkg;
   import stbuf_cfg_pkg::*;

   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } access_size_t;

   // store as it arrives in dc3 with data right aligned
   typedef struct packed {
      logic              vld;
      logic [ADDR_W-1:0] addr;
      access_size_t      size;
      logic [DATA_W-1:0] data;
   } store_req_t;

   // one word image held in the buffer and sent on drain
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [BYTE_W-1:0] byteen;
      logic [DATA_W-1:0] data;   // already shifted to byte lanes
   } stbuf_entry_t;

   typedef struct packed {
      logic              vld;
      logic [ADDR_W-1:0] addr;
      access_size_t      size;
   } load_req_t;

   typedef struct packed {
      logic [BYTE_W-1:0] byteen;   // bytes supplied by the buffer
      logic [DATA_W-1:0] data;
   } fwd_result_t;

endpackage

//--- logic/stbuf_cfg_pkg.sv
package stbuf_cfg_pkg;

   // ---------------------------------------------------------------------
   // buffer geometry
   // ---------------------------------------------------------------------
   localparam int STBUF_DEPTH   = 4;    // entries
   localparam int STBUF_PTR_W   = 2;    // log2 of depth

   // ---------------------------------------------------------------------
   // address and data shape of one entry
   // ---------------------------------------------------------------------
   localparam int ADDR_W        = 16;   // byte address
   localparam int DATA_W        = 32;
   localparam int BYTE_W        = 4;    // bytes per word
   localparam int WORD_ADDR_LSB = 2;    // first bit above the byte offset

endpackage
